// ==== build.f ====
+incdir+include
logic/fe_pkg.sv
logic/fetch_pc_counter.sv
logic/fetch_ctrl_fsm.sv
logic/instr_buffer.sv
logic/instr_predecode.sv
logic/frontend_top.sv
dv/frontend_tb.sv

// ==== dv/frontend_tb.sv ====
`timescale 1ns/1ps
`include "fe_consts.svh"

module frontend_tb
    import fe_pkg::*;
();

    localparam int ID_W            = `FE_ID_WIDTH;
    localparam int IF_W            = `FE_IF_WIDTH;
    localparam int RESET_CYCLES    = 16;
    localparam int RUN_CYCLES      = 400;
    localparam int STALL_CYCLES    = 60;
    localparam int REDIRECT_CYCLES = 1200;
    localparam int DRAIN_CYCLES    = 200;
    localparam int TEST_CYCLES     = RESET_CYCLES + RUN_CYCLES + STALL_CYCLES
                                     + REDIRECT_CYCLES + DRAIN_CYCLES;
    localparam int TIMEOUT_NS      = TEST_CYCLES * 20 + 2000;

    // Stimulus modes of the backend and redirect drivers
    localparam int MODE_RUN      = 0;
    localparam int MODE_STALL    = 1;
    localparam int MODE_REDIRECT = 2;

    logic                         clk = 1'b0;
    logic                         rst_n;
    logic                         fetch_ready;
    instr_word_u [IF_W-1:0]       fetch_data;
    logic        [ID_W-1:0]       issue_accept;
    logic                         redirect;
    logic        [31:0]           redirect_pc;
    logic                         fetch_valid;
    logic        [31:0]           fetch_pc;
    logic        [ID_W-1:0]       issue_valid;
    logic        [ID_W-1:0][31:0] issue_pc;
    instr_word_u [ID_W-1:0]       issue_instr;
    logic        [ID_W-1:0][4:0]  issue_rd;
    logic        [ID_W-1:0][4:0]  issue_rs1;
    logic        [ID_W-1:0][4:0]  issue_rs2;
    logic        [ID_W-1:0]       issue_uses_imm;
    logic        [ID_W-1:0][31:0] issue_imm;

    // Instruction source contents indexed by address bits 9:2
    logic [31:0] imem [256];

    integer      seed = 57;
    int          mode = MODE_RUN;
    logic        run_active = 1'b0;
    logic [31:0] exp_pc = `FE_RESET_PC;
    logic        seen_first = 1'b0;
    int          accepted_total = 0;
    logic        redirect_open = 1'b0;
    int          redirect_hits = 0;
    int          stall_mark;

    // Values seen mid-cycle for use at the following rising edge
    logic [ID_W-1:0] snap_valid;
    logic [31:0]     snap_pc0;
    logic            snap_fvalid;
    logic [31:0]     snap_fpc;
    logic            hold_pend = 1'b0;
    logic [31:0]     hold_pc;
    logic            flush_pend = 1'b0;

    frontend_top DUT (
        .clk              (clk),
        .rst_n            (rst_n),
        .fetch_ready_i    (fetch_ready),
        .fetch_data_i     (fetch_data),
        .issue_accept_i   (issue_accept),
        .redirect_i       (redirect),
        .redirect_pc_i    (redirect_pc),
        .fetch_valid_o    (fetch_valid),
        .fetch_pc_o       (fetch_pc),
        .issue_valid_o    (issue_valid),
        .issue_pc_o       (issue_pc),
        .issue_instr_o    (issue_instr),
        .issue_rd_o       (issue_rd),
        .issue_rs1_o      (issue_rs1),
        .issue_rs2_o      (issue_rs2),
        .issue_uses_imm_o (issue_uses_imm),
        .issue_imm_o      (issue_imm)
    );

    always #4 clk = ~clk;

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("Simulation finished: FAIL");
        $fatal(1, "stopping at first error");
    endtask

    function automatic logic [31:0] mem_word(input logic [31:0] addr);
        return imem[addr[9:2]];
    endfunction

    task automatic wait_for_accepts(input int target);
        while (accepted_total < target) begin
            @(negedge clk);
        end
    endtask

    // Mid-cycle checks of the issue slots and the fetch request
    always @(negedge clk) begin
        logic [31:0] slot_pc;
        logic [31:0] word;
        logic        exp_uses;
        logic [31:0] exp_imm;

        if (!rst_n) begin
            assert (!fetch_valid && issue_valid == '0)
            else abort_run($sformatf("mismatch at %0t: in reset fetch valid %b issue valid %b",
                                     $time, fetch_valid, issue_valid));
        end

        if (hold_pend) begin
            assert (fetch_valid && fetch_pc == hold_pc)
            else abort_run($sformatf("mismatch at %0t: held request valid %b pc %h, expected pc %h",
                                     $time, fetch_valid, fetch_pc, hold_pc));
        end

        // Buffer must be empty right after a redirect
        if (flush_pend) begin
            assert (issue_valid == '0)
            else abort_run($sformatf("mismatch at %0t: issue valid %b after redirect, expected 0",
                                     $time, issue_valid));
        end

        for (int j = 0; j < ID_W; j++) begin
            if (issue_valid[j]) begin
                slot_pc  = exp_pc + 32'(4 * j);
                word     = mem_word(slot_pc);
                exp_uses = (word[6:0] == 7'b0010011) || (word[6:0] == 7'b0000011);
                exp_imm  = exp_uses ? {{20{word[31]}}, word[31:20]} : 32'd0;
                assert (issue_pc[j] == slot_pc)
                else abort_run($sformatf("mismatch at %0t: slot %0d pc %h, expected %h",
                                         $time, j, issue_pc[j], slot_pc));
                assert (issue_instr[j] == word)
                else abort_run($sformatf("mismatch at %0t: slot %0d word %h, expected %h",
                                         $time, j, issue_instr[j], word));
                assert (issue_rd[j] == word[11:7] && issue_rs1[j] == word[19:15]
                        && issue_rs2[j] == word[24:20] && issue_uses_imm[j] == exp_uses
                        && issue_imm[j] == exp_imm)
                else abort_run($sformatf("mismatch at %0t: slot %0d predecode of %h, imm %h vs %h",
                                         $time, j, word, issue_imm[j], exp_imm));
            end
        end

        snap_valid  = issue_valid;
        snap_pc0    = issue_pc[0];
        snap_fvalid = fetch_valid;
        snap_fpc    = fetch_pc;
        hold_pend   = rst_n && fetch_valid && !fetch_ready && !redirect;
        hold_pc     = fetch_pc;
        flush_pend  = 1'b0;
    end

    // Model update for this edge and inputs for the next cycle
    always @(posedge clk) begin
        int   n_acc;
        int   n_valid;
        int   room;
        int   n_next;
        logic fire_now;

        if (run_active) begin
            n_acc   = 0;
            n_valid = 0;
            for (int j = 0; j < ID_W; j++) begin
                n_valid = n_valid + int'(snap_valid[j]);
                n_acc   = n_acc + int'(issue_accept[j]);
            end

            if (redirect) begin
                exp_pc        = redirect_pc;
                seen_first    = 1'b1;
                flush_pend    = 1'b1;
                redirect_open = 1'b1;
            end else begin
                for (int j = 0; j < ID_W; j++) begin
                    if (issue_accept[j]) begin
                        assert (snap_valid[j])
                        else abort_run($sformatf("mismatch at %0t: slot %0d accepted while not valid",
                                                 $time, j));
                        if (!seen_first) begin
                            assert (snap_pc0 == `FE_RESET_PC)
                            else abort_run($sformatf("mismatch at %0t: first pc %h, expected %h",
                                                     $time, snap_pc0, `FE_RESET_PC));
                            seen_first = 1'b1;
                        end
                        if (redirect_open) begin
                            redirect_hits = redirect_hits + 1;
                            redirect_open = 1'b0;
                        end
                        exp_pc         = exp_pc + 32'd4;
                        accepted_total = accepted_total + 1;
                    end
                end
            end

            // Source answers one cycle after a stable request
            fire_now = snap_fvalid && fetch_ready && !redirect;
            if (fire_now || redirect) begin
                fetch_ready <= 1'b0;
            end else begin
                for (int k = 0; k < IF_W; k++) begin
                    fetch_data[k] <= mem_word(snap_fpc + 32'(4 * k));
                end
                fetch_ready <= ({$random(seed)} % 4) != 0;
            end

            if (mode == MODE_REDIRECT && !redirect && ({$random(seed)} % 24) == 0) begin
                redirect    <= 1'b1;
                redirect_pc <= $random(seed) & 32'hffff_fff8;
            end else begin
                redirect <= 1'b0;
            end

            // Prefix accept bounded by entries surely present next cycle
            room = redirect ? 0 : n_valid - n_acc;
            if (mode == MODE_STALL) begin
                room = 0;
            end
            n_next = {$random(seed)} % (ID_W + 1);
            if (n_next > room) begin
                n_next = room;
            end
            issue_accept <= ID_W'((1 << n_next) - 1);
        end
    end

    initial begin
        logic [31:0] w;
        int          sel;

        rst_n        = 1'b0;
        fetch_ready  = 1'b0;
        fetch_data   = '0;
        issue_accept = '0;
        redirect     = 1'b0;
        redirect_pc  = '0;

        // Half the words get an immediate-form opcode
        for (int i = 0; i < 256; i++) begin
            w   = $random(seed);
            sel = {$random(seed)} % 4;
            if (sel == 0) begin
                w[6:0] = 7'b0010011;
            end else if (sel == 1) begin
                w[6:0] = 7'b0000011;
            end
            imem[i] = w;
        end

        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        assert (!fetch_valid && issue_valid == '0)
        else abort_run($sformatf("mismatch at %0t: after reset fetch valid %b issue valid %b",
                                 $time, fetch_valid, issue_valid));
        run_active = 1'b1;

        repeat (RUN_CYCLES) @(negedge clk);
        assert (accepted_total > 0)
        else abort_run("No instruction was accepted in the random run");

        mode = MODE_STALL;
        repeat (STALL_CYCLES) @(negedge clk);
        assert (!fetch_valid && issue_valid == '1)
        else abort_run($sformatf("mismatch at %0t: full buffer fetch valid %b issue valid %b",
                                 $time, fetch_valid, issue_valid));
        stall_mark = accepted_total;
        mode       = MODE_RUN;
        wait_for_accepts(stall_mark + 16);

        mode = MODE_REDIRECT;
        repeat (REDIRECT_CYCLES) @(negedge clk);
        assert (redirect_hits > 0)
        else abort_run("No instruction was accepted after any redirect in the redirect run");

        mode = MODE_RUN;
        wait_for_accepts(accepted_total + 32);

        $display("Simulation finished: PASS");
        $finish;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("Timeout: the run did not complete within %0d ns", TIMEOUT_NS);
        $display("Simulation finished: FAIL");
        $fatal(1, "watchdog expired");
    end

endmodule

// ==== include/fe_consts.svh ====
`ifndef FE_CONSTS_SVH
`define FE_CONSTS_SVH

// Instruction words delivered by one fetch transfer
`define FE_IF_WIDTH 2

// Issue slots presented to the backend
`define FE_ID_WIDTH 2

// Number of instruction buffer entries as a power of two
`define FE_IBUF_DEPTH 8

// First fetch address out of reset
`define FE_RESET_PC 32'h0000_1000

// Byte stride of one instruction word
`define FE_INSTR_BYTES 4

`endif

// ==== logic/fe_pkg.sv ====
package fe_pkg;

    // Register form with the R-type field layout
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } instr_rform_t;

    // Immediate form with the I-type field layout
    typedef struct packed {
        logic [11:0] imm12;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } instr_iform_t;

    // One 32-bit instruction word in either decoding
    typedef union packed {
        instr_rform_t rform;
        instr_iform_t iform;
    } instr_word_u;

endpackage

// ==== logic/fetch_ctrl_fsm.sv ====
`timescale 1ns/1ps

module fetch_ctrl_fsm (
    input  logic clk,
    input  logic rst_n,
    input  logic redirect_i,
    input  logic space_ok_i,
    input  logic fetch_ready_i,
    output logic fetch_valid_o,
    output logic fetch_fire_o,
    output logic load_redirect_o,
    output logic flush_o
);

    localparam logic [1:0] ST_IDLE     = 2'd0;
    localparam logic [1:0] ST_FETCH    = 2'd1;
    localparam logic [1:0] ST_HOLD     = 2'd2;
    localparam logic [1:0] ST_REDIRECT = 2'd3;

    logic [1:0] state_q;
    logic [1:0] state_d;

    // Next state
    always_comb begin
        state_d = state_q;
        if (redirect_i) begin
            state_d = ST_REDIRECT;
        end else begin
            case (state_q)
                ST_IDLE: begin
                    state_d = ST_FETCH;
                end
                ST_FETCH: begin
                    if (!space_ok_i) begin
                        state_d = ST_HOLD;
                    end
                end
                ST_HOLD: begin
                    if (space_ok_i) begin
                        state_d = ST_FETCH;
                    end
                end
                ST_REDIRECT: begin
                    state_d = ST_FETCH;
                end
                default: begin
                    state_d = ST_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= ST_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // Request only while room for a full group is known
    assign fetch_valid_o = (state_q == ST_FETCH) && space_ok_i;

    // A transfer in the redirect cycle is dropped
    assign fetch_fire_o = fetch_valid_o && fetch_ready_i && !redirect_i;

    // Same strobe flushes the buffer and reloads the PC
    assign load_redirect_o = redirect_i;
    assign flush_o         = redirect_i;

endmodule

// ==== logic/fetch_pc_counter.sv ====
`timescale 1ns/1ps
`include "fe_consts.svh"

module fetch_pc_counter (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        fetch_fire_i,
    input  logic        load_redirect_i,
    input  logic [31:0] redirect_pc_i,
    output logic [31:0] pc_o
);

    // Bytes covered by one fetched group
    localparam logic [31:0] FETCH_STRIDE = 32'(`FE_IF_WIDTH * `FE_INSTR_BYTES);

    logic [31:0] pc_q;
    logic [31:0] pc_d;

    // Redirect wins over a normal advance
    always_comb begin
        pc_d = pc_q;
        if (load_redirect_i) begin
            pc_d = redirect_pc_i;
        end else if (fetch_fire_i) begin
            pc_d = pc_q + FETCH_STRIDE;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc_q <= `FE_RESET_PC;
        end else begin
            pc_q <= pc_d;
        end
    end

    assign pc_o = pc_q;

endmodule

// ==== logic/frontend_top.sv ====
`timescale 1ns/1ps
`include "fe_consts.svh"

module frontend_top
    import fe_pkg::*;
(
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  logic                                 fetch_ready_i,
    input  instr_word_u [`FE_IF_WIDTH-1:0]       fetch_data_i,
    input  logic        [`FE_ID_WIDTH-1:0]       issue_accept_i,
    input  logic                                 redirect_i,
    input  logic        [31:0]                   redirect_pc_i,
    output logic                                 fetch_valid_o,
    output logic        [31:0]                   fetch_pc_o,
    output logic        [`FE_ID_WIDTH-1:0]       issue_valid_o,
    output logic        [`FE_ID_WIDTH-1:0][31:0] issue_pc_o,
    output instr_word_u [`FE_ID_WIDTH-1:0]       issue_instr_o,
    output logic        [`FE_ID_WIDTH-1:0][4:0]  issue_rd_o,
    output logic        [`FE_ID_WIDTH-1:0][4:0]  issue_rs1_o,
    output logic        [`FE_ID_WIDTH-1:0][4:0]  issue_rs2_o,
    output logic        [`FE_ID_WIDTH-1:0]       issue_uses_imm_o,
    output logic        [`FE_ID_WIDTH-1:0][31:0] issue_imm_o
);

    logic fetch_fire;
    logic load_redirect;
    logic flush;
    logic space_ok;

    fetch_pc_counter u_pc (
        .clk             (clk),
        .rst_n           (rst_n),
        .fetch_fire_i    (fetch_fire),
        .load_redirect_i (load_redirect),
        .redirect_pc_i   (redirect_pc_i),
        .pc_o            (fetch_pc_o)
    );

    fetch_ctrl_fsm u_ctrl (
        .clk             (clk),
        .rst_n           (rst_n),
        .redirect_i      (redirect_i),
        .space_ok_i      (space_ok),
        .fetch_ready_i   (fetch_ready_i),
        .fetch_valid_o   (fetch_valid_o),
        .fetch_fire_o    (fetch_fire),
        .load_redirect_o (load_redirect),
        .flush_o         (flush)
    );

    // Fetched group lands in the buffer on a transfer
    instr_buffer u_ibuf (
        .clk          (clk),
        .rst_n        (rst_n),
        .flush_i      (flush),
        .write_i      (fetch_fire),
        .write_pc_i   (fetch_pc_o),
        .write_data_i (fetch_data_i),
        .accept_i     (issue_accept_i),
        .space_ok_o   (space_ok),
        .head_valid_o (issue_valid_o),
        .head_pc_o    (issue_pc_o),
        .head_instr_o (issue_instr_o)
    );

    instr_predecode u_predec (
        .instr_i    (issue_instr_o),
        .rd_o       (issue_rd_o),
        .rs1_o      (issue_rs1_o),
        .rs2_o      (issue_rs2_o),
        .uses_imm_o (issue_uses_imm_o),
        .imm_o      (issue_imm_o)
    );

endmodule

// ==== logic/instr_buffer.sv ====
`timescale 1ns/1ps
`include "fe_consts.svh"

module instr_buffer
    import fe_pkg::*;
(
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           flush_i,
    input  logic                           write_i,
    input  logic [31:0]                    write_pc_i,
    input  instr_word_u [`FE_IF_WIDTH-1:0] write_data_i,
    input  logic [`FE_ID_WIDTH-1:0]        accept_i,
    output logic                           space_ok_o,
    output logic [`FE_ID_WIDTH-1:0]        head_valid_o,
    output logic [`FE_ID_WIDTH-1:0][31:0]  head_pc_o,
    output instr_word_u [`FE_ID_WIDTH-1:0] head_instr_o
);

    localparam int PTR_W = $clog2(`FE_IBUF_DEPTH);
    localparam int CNT_W = PTR_W + 1;

    localparam logic [CNT_W-1:0] DEPTH_C    = CNT_W'(`FE_IBUF_DEPTH);
    localparam logic [CNT_W-1:0] IF_WIDTH_C = CNT_W'(`FE_IF_WIDTH);

    // Entry storage with one PC per word
    logic [31:0] pc_mem    [`FE_IBUF_DEPTH];
    instr_word_u instr_mem [`FE_IBUF_DEPTH];

    logic [PTR_W-1:0] rd_ptr_q;
    logic [PTR_W-1:0] wr_ptr_q;
    logic [CNT_W-1:0] count_q;

    logic [`FE_ID_WIDTH-1:0] accept_eff;
    logic [CNT_W-1:0]        pop_num;
    logic [CNT_W-1:0]        push_num;
    logic [CNT_W-1:0]        free_num;

    // Only entries that are present can leave
    assign accept_eff = accept_i & head_valid_o;

    // Number of entries leaving this cycle
    always_comb begin
        pop_num = '0;
        for (int j = 0; j < `FE_ID_WIDTH; j++) begin
            pop_num = pop_num + CNT_W'(accept_eff[j]);
        end
    end

    assign push_num = write_i ? IF_WIDTH_C : '0;

    // Free space from the current occupancy only
    assign free_num   = DEPTH_C - count_q;
    assign space_ok_o = (free_num >= IF_WIDTH_C);

    // Pointer and occupancy control
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;
            count_q  <= '0;
        end else if (flush_i) begin
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            rd_ptr_q <= rd_ptr_q + pop_num[PTR_W-1:0];
            wr_ptr_q <= wr_ptr_q + push_num[PTR_W-1:0];
            count_q  <= count_q + push_num - pop_num;
        end
    end

    // Write slots wrap around the ring
    logic [PTR_W-1:0] wr_idx [`FE_IF_WIDTH];
    logic [31:0]      wr_pc  [`FE_IF_WIDTH];

    for (genvar k = 0; k < `FE_IF_WIDTH; k++) begin : g_wr_slot
        assign wr_idx[k] = wr_ptr_q + PTR_W'(k);
        assign wr_pc[k]  = write_pc_i + 32'(k * `FE_INSTR_BYTES);
    end

    always_ff @(posedge clk) begin
        if (write_i && !flush_i) begin
            for (int k = 0; k < `FE_IF_WIDTH; k++) begin
                pc_mem[wr_idx[k]]    <= wr_pc[k];
                instr_mem[wr_idx[k]] <= write_data_i[k];
            end
        end
    end

    // Head slots come straight from the stored entries
    for (genvar j = 0; j < `FE_ID_WIDTH; j++) begin : g_head_slot
        logic [PTR_W-1:0] rd_idx;

        assign rd_idx          = rd_ptr_q + PTR_W'(j);
        assign head_valid_o[j] = (count_q > CNT_W'(j));
        assign head_pc_o[j]    = pc_mem[rd_idx];
        assign head_instr_o[j] = instr_mem[rd_idx];
    end

endmodule

// ==== logic/instr_predecode.sv ====
`timescale 1ns/1ps
`include "fe_consts.svh"

module instr_predecode
    import fe_pkg::*;
(
    input  instr_word_u [`FE_ID_WIDTH-1:0]       instr_i,
    output logic        [`FE_ID_WIDTH-1:0][4:0]  rd_o,
    output logic        [`FE_ID_WIDTH-1:0][4:0]  rs1_o,
    output logic        [`FE_ID_WIDTH-1:0][4:0]  rs2_o,
    output logic        [`FE_ID_WIDTH-1:0]       uses_imm_o,
    output logic        [`FE_ID_WIDTH-1:0][31:0] imm_o
);

    // Opcodes carrying a 12-bit I-type immediate
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;

    for (genvar j = 0; j < `FE_ID_WIDTH; j++) begin : g_slot
        instr_rform_t rf;
        instr_iform_t itf;
        logic         is_imm;

        // Both views of the same word
        assign rf  = instr_i[j].rform;
        assign itf = instr_i[j].iform;

        assign rd_o[j]  = rf.rd;
        assign rs1_o[j] = rf.rs1;
        assign rs2_o[j] = rf.rs2;

        assign is_imm = (itf.opcode == OPC_OP_IMM) || (itf.opcode == OPC_LOAD);

        assign uses_imm_o[j] = is_imm;

        // Sign-extended imm12 or zero for other opcodes
        assign imm_o[j] = is_imm ? {{20{itf.imm12[11]}}, itf.imm12} : 32'd0;
    end

endmodule
